//--- design/bridge_pkg.sv
package bridge_pkg;

    // Framing
    localparam logic [7:0] sof_byte = 8'h5A;     // Host to device start byte

    // Status codes returned with every parsed frame
    localparam logic [7:0] status_ok      = 8'h00;
    localparam logic [7:0] status_crc_err = 8'h01;
    localparam logic [7:0] status_cmd_inv = 8'h02;
    localparam logic [7:0] status_timeout = 8'h04;

    // Size code 3 has no beat width
    localparam logic [1:0] size_reserved = 2'b11;

    // Serial timing, all in clk cycles
    localparam int clks_per_bit = 16;
    localparam int byte_clks    = 10 * clks_per_bit;  // Start, eight data, stop
    localparam int timeout_clks = 10 * byte_clks;     // Idle gap that aborts a frame

    // Receive buffering
    localparam int fifo_depth = 16;
    localparam int fifo_aw    = 4;       // log2 of fifo_depth
    localparam int max_data   = 64;      // 16 beats of 4 bytes

    // Command byte as sent on the wire, MSB first in the struct
    typedef struct packed {
        logic       rw;      // 1 means read
        logic       inc;     // Address increments per beat
        logic [1:0] size;    // 0, 1, 2 give 1, 2, 4 bytes per beat
        logic [3:0] len;     // Beats minus one
    } cmd_t;

    // Parsed frame held for the consumer
    typedef struct packed {
        cmd_t        cmd;
        logic [31:0] addr;       // Little-endian on the wire
        logic [6:0]  count;      // Data bytes received, 0 to 64
        logic [7:0]  status;
    } frame_t;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] byte_data,
    output logic       byte_strobe
);
    import bridge_pkg::*;

    typedef logic [$clog2(clks_per_bit)-1:0] tick_t;
    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

    rx_state_t  state;
    logic       rxd_meta;
    logic       rxd_sync;
    tick_t      tick;
    logic [2:0] bit_idx;
    logic [7:0] shreg;
    logic       bit_mid;

    // Line idles high, so the synchronizer comes out of reset high
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign bit_mid = (tick == tick_t'(clks_per_bit - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= rx_idle;
            tick        <= '0;
            bit_idx     <= '0;
            byte_strobe <= 1'b0;
        end else begin
            byte_strobe <= 1'b0;
            tick        <= tick + 1'b1;
            case (state)
                rx_idle: begin
                    tick <= '0;
                    if (!rxd_sync) begin
                        state <= rx_start;
                    end
                end
                // Sync flops and the idle check already cost four cycles of the half bit
                rx_start: begin
                    if (tick == tick_t'(clks_per_bit / 2 - 4)) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? rx_idle : rx_data;  // High again means a glitch
                    end
                end
                rx_data: begin
                    if (bit_mid) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                rx_stop: begin
                    if (bit_mid) begin
                        byte_strobe <= rxd_sync;      // Framing error drops the byte
                        state       <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == rx_data && bit_mid) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

    assign byte_data = shreg;

endmodule

//--- design/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] wr_data,
    input  logic       wr_en,
    input  logic       rd_en,
    output logic [7:0] head,
    output logic       empty
);
    import bridge_pkg::*;

    typedef logic [fifo_aw:0] occ_t;

    logic [7:0]         mem [fifo_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    occ_t               count;
    logic               full;
    logic               push;
    logic               pop;

    assign empty = (count == '0);
    assign full  = (count == occ_t'(fifo_depth));
    assign push  = wr_en && !full;      // Overflow byte is lost
    assign pop   = rd_en && !empty;

    // Oldest entry is visible without a read cycle
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/crc8_calc.sv
`timescale 1ns/1ps

module crc8_calc (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       en,
    input  logic [7:0] data,
    output logic [7:0] crc
);

    logic [7:0] next_crc;

    // MSB-first CRC-8, x^8 + x^2 + x + 1, one whole byte per cycle
    always_comb begin
        next_crc = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            if (next_crc[7]) begin
                next_crc = {next_crc[6:0], 1'b0} ^ 8'h07;
            end else begin
                next_crc = {next_crc[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= 8'h00;        // Clear beats en
        end else if (en) begin
            crc <= next_crc;
        end
    end

endmodule

//--- design/frame_parser.sv
`timescale 1ns/1ps

module frame_parser (
    input  logic              clk,
    input  logic              rst,
    input  logic [7:0]        head,
    input  logic              empty,
    input  logic [7:0]        crc,
    input  logic              frame_consumed,
    input  logic [5:0]        data_idx,
    output logic              rd_en,
    output logic              crc_clear,
    output logic              crc_en,
    output logic [7:0]        crc_byte,
    output bridge_pkg::frame_t frame,
    output logic              frame_valid,
    output logic              frame_error,
    output logic              parser_busy,
    output logic [7:0]        data_byte
);
    import bridge_pkg::*;

    typedef logic [$clog2(timeout_clks)-1:0] idle_cnt_t;
    typedef enum logic [3:0] {
        st_idle,
        st_cmd,
        st_addr0,
        st_addr1,
        st_addr2,
        st_addr3,
        st_data,
        st_crc,
        st_done,
        st_timeout
    } state_t;

    state_t      state;
    cmd_t        cmd_q;
    logic [31:0] addr_q;
    logic [6:0]  count_q;
    logic [7:0]  status_q;
    logic [7:0]  data_buf [max_data];
    logic [6:0]  exp_count;
    idle_cnt_t   idle_cnt;
    logic        pop;
    logic        in_frame;
    logic        holding;
    logic        timeout_hit;

    assign pop      = rd_en && !empty;
    assign in_frame = (state != st_idle) && !holding;
    assign holding  = (state == st_done) || (state == st_timeout);

    // Writes carry (len+1) beats of 1, 2 or 4 bytes; reads and reserved sizes none
    always_comb begin
        if (cmd_q.rw || cmd_q.size == size_reserved) begin
            exp_count = 7'd0;
        end else begin
            exp_count = ({3'b000, cmd_q.len} + 7'd1) << cmd_q.size;
        end
    end

    // Registered pop request, one cycle after a byte shows at head
    // Every other cycle at most, so rd_en never outlives the byte it asked for
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en <= 1'b0;
        end else begin
            rd_en <= !empty && !rd_en && !holding;
        end
    end

    // Idle line watchdog inside a frame, restarts while a byte waits
    always_ff @(posedge clk) begin
        if (rst || !in_frame || !empty) begin
            idle_cnt <= '0;
        end else begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign timeout_hit = in_frame && empty && (idle_cnt == idle_cnt_t'(timeout_clks - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            count_q  <= '0;
            status_q <= status_ok;
        end else begin
            case (state)
                st_idle: begin
                    // Anything but the start byte is thrown away
                    if (pop && head == sof_byte) begin
                        state   <= st_cmd;
                        count_q <= '0;
                    end
                end
                st_cmd:   if (pop) state <= st_addr0;
                st_addr0: if (pop) state <= st_addr1;
                st_addr1: if (pop) state <= st_addr2;
                st_addr2: if (pop) state <= st_addr3;
                st_addr3: begin
                    if (pop) begin
                        state <= (exp_count == 7'd0) ? st_crc : st_data;
                    end
                end
                st_data: begin
                    if (pop) begin
                        count_q <= count_q + 7'd1;
                        if (count_q + 7'd1 == exp_count) begin
                            state <= st_crc;
                        end
                    end
                end
                st_crc: begin
                    // Status fixed on entry to done, command check first
                    if (pop) begin
                        state <= st_done;
                        if (cmd_q.size == size_reserved) begin
                            status_q <= status_cmd_inv;
                        end else if (head != crc) begin
                            status_q <= status_crc_err;
                        end else begin
                            status_q <= status_ok;
                        end
                    end
                end
                st_done, st_timeout: begin
                    if (frame_consumed) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
            if (timeout_hit) begin
                state    <= st_timeout;
                status_q <= status_timeout;
            end
        end
    end

    // Frame contents, loaded as their bytes are popped
    always_ff @(posedge clk) begin
        if (pop) begin
            case (state)
                st_cmd:   cmd_q         <= head;
                st_addr0: addr_q[7:0]   <= head;
                st_addr1: addr_q[15:8]  <= head;
                st_addr2: addr_q[23:16] <= head;
                st_addr3: addr_q[31:24] <= head;
                st_data:  data_buf[count_q[5:0]] <= head;
                default:  addr_q        <= addr_q;
            endcase
        end
    end

    // CRC runs over command, address and data only
    assign crc_clear = (state == st_idle);
    assign crc_en    = pop && (state != st_idle) && (state != st_crc);
    assign crc_byte  = head;

    assign frame = '{cmd: cmd_q, addr: addr_q, count: count_q, status: status_q};

    assign frame_valid = (state == st_done) && (status_q == status_ok);
    assign frame_error = (state == st_timeout)
                      || ((state == st_done) && (status_q != status_ok));
    assign parser_busy = (state != st_idle);

    assign data_byte = data_buf[data_idx];

endmodule

//--- design/frame_rx_top.sv
`timescale 1ns/1ps

module frame_rx_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               rxd,
    input  logic               frame_consumed,
    input  logic [5:0]         data_idx,
    output bridge_pkg::frame_t frame,
    output logic               frame_valid,
    output logic               frame_error,
    output logic               parser_busy,
    output logic [7:0]         data_byte
);

    logic [7:0] byte_data;
    logic       byte_strobe;
    logic [7:0] head;
    logic       empty;
    logic       rd_en;
    logic       crc_clear;
    logic       crc_en;
    logic [7:0] crc_byte;
    logic [7:0] crc;

    uart_rx u_uart_rx (
        .clk         (clk),
        .rst         (rst),
        .rxd         (rxd),
        .byte_data   (byte_data),
        .byte_strobe (byte_strobe)
    );

    // Absorbs bytes while a parsed frame waits for the consumer
    byte_fifo u_byte_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (byte_data),
        .wr_en   (byte_strobe),
        .rd_en   (rd_en),
        .head    (head),
        .empty   (empty)
    );

    crc8_calc u_crc8_calc (
        .clk   (clk),
        .rst   (rst),
        .clear (crc_clear),
        .en    (crc_en),
        .data  (crc_byte),
        .crc   (crc)
    );

    frame_parser u_frame_parser (
        .clk            (clk),
        .rst            (rst),
        .head           (head),
        .empty          (empty),
        .crc            (crc),
        .frame_consumed (frame_consumed),
        .data_idx       (data_idx),
        .rd_en          (rd_en),
        .crc_clear      (crc_clear),
        .crc_en         (crc_en),
        .crc_byte       (crc_byte),
        .frame          (frame),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .parser_busy    (parser_busy),
        .data_byte      (data_byte)
    );

endmodule

//--- bench/frame_rx_chk.sv
`timescale 1ns/1ps

module frame_rx_chk (
    input logic clk,
    input logic rst,
    input logic rd_en,
    input logic empty,
    input logic frame_valid,
    input logic frame_error,
    input logic frame_consumed
);

    // Failure counts, one per property
    int n_both  = 0;
    int n_empty = 0;
    int n_drop  = 0;
    int n_stall = 0;

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(frame_valid && frame_error))
        else begin
            n_both++;
            $error("frame_valid and frame_error high together");
        end

    // No pop request against an empty FIFO
    a_pop_needs_data: assert property (@(posedge clk) disable iff (rst)
        !(rd_en && empty))
        else begin
            n_empty++;
            $error("rd_en high while FIFO empty");
        end

    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        frame_valid && !frame_consumed |=> frame_valid)
        else begin
            n_drop++;
            $error("frame_valid fell before frame_consumed");
        end

    a_no_pop_when_held: assert property (@(posedge clk) disable iff (rst)
        (frame_valid || frame_error) |-> !rd_en)
        else begin
            n_stall++;
            $error("rd_en high while a frame is held");
        end

endmodule

//--- bench/frame_rx_tb.sv
`timescale 1ns/1ps

module frame_rx_tb;
    import bridge_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    logic       clk = 1'b0;
    logic       rst;
    logic       rxd;
    logic       frame_consumed;
    logic [5:0] data_idx;
    frame_t     frame;
    logic       frame_valid;
    logic       frame_error;
    logic       parser_busy;
    logic [7:0] data_byte;

    frame_t      exp_frames [$];
    logic [7:0]  exp_data [$];
    int          holds [$];          // Cycles the consumer waits before acking
    int          frames_sent    = 0;
    int          frames_checked = 0;
    int          budget         = 3000;  // Watchdog limit in cycles, grows per frame
    int          elapsed        = 0;
    logic [31:0] lcg_state      = 32'h861aafb7;

    frame_rx_top dut (
        .clk            (clk),
        .rst            (rst),
        .rxd            (rxd),
        .frame_consumed (frame_consumed),
        .data_idx       (data_idx),
        .frame          (frame),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .parser_busy    (parser_busy),
        .data_byte      (data_byte)
    );

    bind frame_parser frame_rx_chk chk (
        .clk            (clk),
        .rst            (rst),
        .rd_en          (rd_en),
        .empty          (empty),
        .frame_valid    (frame_valid),
        .frame_error    (frame_error),
        .frame_consumed (frame_consumed)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Bit-serial CRC-8, poly 0x07, over q[first..last]
    function automatic logic [7:0] crc8_ref(input byte_q_t q, input int first, input int last);
        logic [7:0] crc;
        logic       fb;
        crc = 8'h00;
        for (int i = first; i <= last; i++) begin
            for (int b = 7; b >= 0; b--) begin
                fb  = crc[7] ^ q[i][b];
                crc = {crc[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
            end
        end
        return crc;
    endfunction

    // Data bytes on the wire for a command
    function automatic int data_len(input cmd_t c);
        if (c.rw || c.size == 2'd3) begin
            return 0;
        end
        return (int'(c.len) + 1) * (1 << c.size);
    endfunction

    // Expected parse result of the bytes sent, starting at the start byte
    function automatic frame_t expect_frame(input byte_q_t q, input bit cut);
        frame_t f;
        int     n;
        f.cmd   = cmd_t'(q[1]);
        f.addr  = {q[5], q[4], q[3], q[2]};
        n       = data_len(f.cmd);
        f.count = 7'(cut ? 0 : n);
        if (cut) begin
            f.status = status_timeout;
        end else if (f.cmd.size == 2'd3) begin
            f.status = status_cmd_inv;
        end else if (crc8_ref(q, 1, 5 + n) != q[6 + n]) begin
            f.status = status_crc_err;
        end else begin
            f.status = status_ok;
        end
        return f;
    endfunction

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        assert (act_val === exp_val)
            else report_fail($sformatf("mismatch %s expected 0x%0h actual 0x%0h",
                                       name, exp_val, act_val));
    endtask

    // Start, eight data bits LSB first, one stop bit; entered just after an edge
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            rxd = bits[k];
            repeat (clks_per_bit) @(posedge clk);
            #1;
        end
    endtask

    task automatic send_junk(input logic [7:0] b);
        budget += byte_clks * 2;
        send_byte(b);
    endtask

    task automatic send_frame(input cmd_t c, input logic [31:0] addr, input bit bad_crc,
                              input bit cut, input int hold);
        byte_q_t     q;
        int          n;
        logic [31:0] r;
        logic [7:0]  crc;
        n = data_len(c);
        q.push_back(sof_byte);
        q.push_back(c);
        for (int i = 0; i < 4; i++) begin
            q.push_back(addr[8*i +: 8]);     // Little-endian
        end
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            q.push_back(r[23:16]);
        end
        crc = crc8_ref(q, 1, q.size() - 1);
        if (cut) begin
            q = q[0:5];                     // Stop after the address
        end else begin
            q.push_back(bad_crc ? crc ^ 8'h01 : crc);
        end
        exp_frames.push_back(expect_frame(q, cut));
        for (int i = 0; i < (cut ? 0 : n); i++) begin
            exp_data.push_back(q[6 + i]);
        end
        holds.push_back(hold);
        budget += q.size() * byte_clks * 2 + hold + (cut ? timeout_clks + 200 : 0);
        frames_sent++;
        foreach (q[i]) begin
            send_byte(q[i]);
        end
    endtask

    task automatic wait_done();
        @(posedge clk);
        while (frames_checked != frames_sent) begin
            @(posedge clk);
        end
        #1;
    endtask

    initial begin : stimulus
        cmd_t        c;
        logic [31:0] r;
        rxd            = 1'b1;
        rst            = 1'b1;
        frame_consumed = 1'b0;
        data_idx       = '0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;

        // Random writes over all three beat sizes
        for (int i = 0; i < 6; i++) begin
            r      = next_rand();
            c      = cmd_t'(r[31:24]);
            c.rw   = 1'b0;
            c.size = 2'(i % 3);
            send_frame(c, next_rand(), 1'b0, 1'b0, 0);
            wait_done();
        end
        c = '{rw: 1'b0, inc: 1'b1, size: 2'd2, len: 4'hf};   // Full 64 byte buffer
        send_frame(c, next_rand(), 1'b0, 1'b0, 0);
        wait_done();

        c = '{rw: 1'b1, inc: 1'b0, size: 2'd2, len: 4'h3};
        send_frame(c, 32'ha1b2_c3d4, 1'b0, 1'b0, 0);
        wait_done();

        // Bad CRC, then reserved size with a good CRC
        c = '{rw: 1'b0, inc: 1'b0, size: 2'd1, len: 4'h2};
        send_frame(c, next_rand(), 1'b1, 1'b0, 0);
        wait_done();
        c = '{rw: 1'b0, inc: 1'b0, size: 2'd3, len: 4'h5};
        send_frame(c, next_rand(), 1'b0, 1'b0, 0);
        wait_done();

        send_junk(8'h00);
        send_junk(8'ha5);
        send_junk(8'hff);
        c = '{rw: 1'b0, inc: 1'b1, size: 2'd0, len: 4'h7};
        send_frame(c, next_rand(), 1'b0, 1'b0, 0);
        wait_done();

        // Truncated frame must time out, then the parser recovers
        c = '{rw: 1'b0, inc: 1'b0, size: 2'd0, len: 4'h2};
        send_frame(c, next_rand(), 1'b0, 1'b1, 0);
        wait_done();
        c = '{rw: 1'b0, inc: 1'b0, size: 2'd1, len: 4'h1};
        send_frame(c, next_rand(), 1'b0, 1'b0, 0);
        wait_done();

        // Second frame queues in the FIFO while the first is held
        c = '{rw: 1'b0, inc: 1'b1, size: 2'd1, len: 4'h2};
        send_frame(c, next_rand(), 1'b0, 1'b0, 12 * byte_clks);
        c = '{rw: 1'b0, inc: 1'b0, size: 2'd0, len: 4'h3};
        send_frame(c, next_rand(), 1'b0, 1'b0, 0);
        wait_done();

        $display("SIMULATION PASSED");
        $finish;
    end

    // Compare each flagged frame against the model, then acknowledge it
    initial begin : compare
        frame_t exp;
        int     hold;
        forever begin
            @(negedge clk);
            if (frame_valid || frame_error) begin
                if (exp_frames.size() == 0) begin
                    report_fail("DUT flagged a frame that was never sent");
                end
                exp  = exp_frames.pop_front();
                hold = holds.pop_front();
                expect_equal("frame.cmd", 32'(exp.cmd), 32'(frame.cmd));
                expect_equal("frame.addr", exp.addr, frame.addr);
                expect_equal("frame.count", 32'(exp.count), 32'(frame.count));
                expect_equal("frame.status", 32'(exp.status), 32'(frame.status));
                expect_equal("frame_valid", 32'(exp.status == status_ok), 32'(frame_valid));
                expect_equal("frame_error", 32'(exp.status != status_ok), 32'(frame_error));
                expect_equal("parser_busy", 32'd1, 32'(parser_busy));
                for (int i = 0; i < int'(exp.count); i++) begin
                    @(posedge clk);
                    #1 data_idx = 6'(i);
                    @(negedge clk);
                    expect_equal($sformatf("data_byte[%0d]", i), 32'(exp_data.pop_front()),
                                 32'(data_byte));
                end
                repeat (hold) @(posedge clk);
                @(posedge clk);
                #1 frame_consumed = 1'b1;
                @(posedge clk);
                #1 frame_consumed = 1'b0;
                @(negedge clk);
                expect_equal("parser_busy", 32'd0, 32'(parser_busy));
                expect_equal("frame_valid", 32'd0, 32'(frame_valid));
                expect_equal("frame_error", 32'd0, 32'(frame_error));
                frames_checked++;
            end
        end
    end

    always @(posedge clk) begin
        elapsed <= elapsed + 1;
        if (elapsed > budget) begin
            report_fail("watchdog expired, the run hung waiting for the DUT");
        end
    end

    // Picks up the bound parser assertions
    always @(negedge clk) begin
        if (dut.u_frame_parser.chk.n_both + dut.u_frame_parser.chk.n_empty
            + dut.u_frame_parser.chk.n_drop + dut.u_frame_parser.chk.n_stall != 0) begin
            report_fail("a protocol assertion on the frame parser failed");
        end
    end

endmodule

//--- build.f
design/bridge_pkg.sv
design/uart_rx.sv
design/byte_fifo.sv
design/crc8_calc.sv
design/frame_parser.sv
design/frame_rx_top.sv
bench/frame_rx_chk.sv
bench/frame_rx_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the frame receiver testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module frame_rx_tb -f build.f --Mdir "$build_dir" -o frame_rx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/frame_rx_sim" +verilator+error+limit+10 > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
